/* gfx_reg_pkg.sv */
//==========================================================================
// register map and CPU bus widths of the fill engine; imported by the
// register slave, the top level and the testbench
//==========================================================================
`default_nettype none

package gfx_reg_pkg;

  // word indices, taken from address bits 5..2
  localparam int REG_CONTROL     = 0;
  localparam int REG_STATUS      = 1;
  localparam int REG_TARGET_BASE = 2;
  localparam int REG_TARGET_SIZE = 3;  // x low half, y high half
  localparam int REG_DEST0       = 4;
  localparam int REG_DEST1       = 5;
  localparam int REG_CLIP0       = 6;
  localparam int REG_CLIP1       = 7;
  localparam int REG_COLOR       = 8;
  localparam int REG_DEPTH       = 9;

  localparam int CTRL_RECT_BIT = 0;  // control word, starts a fill
  localparam int STAT_BUSY_BIT = 0;  // status word

  localparam int REG_ADR_W  = 4;
  localparam int BUS_DATA_W = 32;
  localparam int BUS_SEL_W  = 4;

endpackage

`default_nettype wire

/* gfx_pix_pkg.sv */
//==========================================================================
// pixel path types: coordinates, color depth and the color word
//==========================================================================
`default_nettype none

package gfx_pix_pkg;

  // unsigned pixel coordinate
  typedef logic [15:0] coord_t;

  // depth code 3 is not named, handled like 32 bit
  typedef enum logic [1:0] {
    DEPTH_8  = 2'd0,
    DEPTH_16 = 2'd1,
    DEPTH_32 = 2'd2
  } depth_e;

  // fill color, read per byte for 8 bit targets and per halfword for 16 bit
  typedef union packed {
    logic [3:0][7:0]  b;
    logic [1:0][15:0] h;
  } color_u;

  // word address width, byte address bits 31..2
  localparam int MEM_ADR_W = 30;

endpackage

`default_nettype wire

/* gfx_reg_slave.sv */
//==========================================================================
// CPU side register slave, holds the render setup and launches fills;
// classic single-beat cycles, response one cycle after the request
//==========================================================================
`default_nettype none

module gfx_reg_slave (
  input  logic                                   wb_clk_i,
  input  logic                                   rst_i,
  input  logic                                   wbs_cyc_i,
  input  logic                                   wbs_stb_i,
  input  logic                                   wbs_we_i,
  input  logic [gfx_reg_pkg::REG_ADR_W-1:0]      wbs_adr_i,
  input  logic [gfx_reg_pkg::BUS_DATA_W-1:0]     wbs_dat_i,
  input  logic                                   busy_i,
  output logic [gfx_reg_pkg::BUS_DATA_W-1:0]     wbs_dat_o,
  output logic                                   wbs_ack_o,
  output logic                                   wbs_err_o,
  output logic                                   rect_start_o,
  output logic [gfx_pix_pkg::MEM_ADR_W-1:0]      target_base_o,
  output gfx_pix_pkg::coord_t                    target_size_x_o,
  output gfx_pix_pkg::coord_t                    target_size_y_o,
  output gfx_pix_pkg::coord_t                    dest0_x_o,
  output gfx_pix_pkg::coord_t                    dest0_y_o,
  output gfx_pix_pkg::coord_t                    dest1_x_o,
  output gfx_pix_pkg::coord_t                    dest1_y_o,
  output gfx_pix_pkg::coord_t                    clip0_x_o,
  output gfx_pix_pkg::coord_t                    clip0_y_o,
  output gfx_pix_pkg::coord_t                    clip1_x_o,
  output gfx_pix_pkg::coord_t                    clip1_y_o,
  output gfx_pix_pkg::color_u                    color_o,
  output gfx_pix_pkg::depth_e                    depth_o
);
  import gfx_reg_pkg::*;
  import gfx_pix_pkg::*;

  logic [BUS_DATA_W-1:0] regs_q [REG_TARGET_BASE:REG_DEPTH];
  logic [BUS_DATA_W-1:0] rd_data;
  logic                  req;
  logic                  bad_idx;
  logic                  setup_idx;
  logic                  engaged;
  logic                  ctrl_go_q;  // start accepted, rides along with ack

  assign req       = wbs_cyc_i & wbs_stb_i & ~wbs_ack_o & ~wbs_err_o;
  assign setup_idx = (wbs_adr_i >= REG_TARGET_BASE) && (wbs_adr_i <= REG_DEPTH);
  assign bad_idx   = (wbs_adr_i > REG_DEPTH) || (wbs_we_i && wbs_adr_i == REG_STATUS);
  // also covers the two cycles between control write and busy
  assign engaged   = busy_i | ctrl_go_q | rect_start_o;

  always_comb begin
    rd_data = '0;  // control reads as zero
    if (wbs_adr_i == REG_STATUS)
      rd_data[STAT_BUSY_BIT] = engaged;
    else if (setup_idx)
      rd_data = regs_q[wbs_adr_i];
  end

  always_ff @(posedge wb_clk_i) begin
    if (rst_i) begin
      wbs_ack_o    <= 1'b0;
      wbs_err_o    <= 1'b0;
      ctrl_go_q    <= 1'b0;
      rect_start_o <= 1'b0;
      for (int i = REG_TARGET_BASE; i <= REG_DEPTH; i++)
        regs_q[i] <= '0;
    end else begin
      wbs_ack_o    <= req & ~bad_idx;
      wbs_err_o    <= req & bad_idx;
      ctrl_go_q    <= req & wbs_we_i & (wbs_adr_i == REG_CONTROL)
                      & wbs_dat_i[CTRL_RECT_BIT] & ~engaged;
      rect_start_o <= ctrl_go_q;
      if (req && wbs_we_i && setup_idx)
        regs_q[wbs_adr_i] <= wbs_dat_i;
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (req)
      wbs_dat_o <= rd_data;
  end

  assign target_base_o   = regs_q[REG_TARGET_BASE][31:2];
  assign target_size_x_o = regs_q[REG_TARGET_SIZE][15:0];
  assign target_size_y_o = regs_q[REG_TARGET_SIZE][31:16];
  assign dest0_x_o       = regs_q[REG_DEST0][15:0];
  assign dest0_y_o       = regs_q[REG_DEST0][31:16];
  assign dest1_x_o       = regs_q[REG_DEST1][15:0];
  assign dest1_y_o       = regs_q[REG_DEST1][31:16];
  assign clip0_x_o       = regs_q[REG_CLIP0][15:0];
  assign clip0_y_o       = regs_q[REG_CLIP0][31:16];
  assign clip1_x_o       = regs_q[REG_CLIP1][15:0];
  assign clip1_y_o       = regs_q[REG_CLIP1][31:16];
  assign color_o         = regs_q[REG_COLOR];
  assign depth_o         = depth_e'(regs_q[REG_DEPTH][1:0]);

endmodule

`default_nettype wire

/* gfx_rect_raster.sv */
//==========================================================================
// rectangle rasterizer, clips against clip rect and target on start and
// hands out pixel coordinates row by row over a valid/ready handshake
//==========================================================================
`default_nettype none

module gfx_rect_raster (
  input  logic                wb_clk_i,
  input  logic                rst_i,
  input  logic                rect_start_i,
  input  gfx_pix_pkg::coord_t target_size_x_i,
  input  gfx_pix_pkg::coord_t target_size_y_i,
  input  gfx_pix_pkg::coord_t dest0_x_i,
  input  gfx_pix_pkg::coord_t dest0_y_i,
  input  gfx_pix_pkg::coord_t dest1_x_i,
  input  gfx_pix_pkg::coord_t dest1_y_i,
  input  gfx_pix_pkg::coord_t clip0_x_i,
  input  gfx_pix_pkg::coord_t clip0_y_i,
  input  gfx_pix_pkg::coord_t clip1_x_i,
  input  gfx_pix_pkg::coord_t clip1_y_i,
  input  logic                pix_ready_i,
  output logic                pix_valid_o,
  output gfx_pix_pkg::coord_t pix_x_o,
  output gfx_pix_pkg::coord_t pix_y_o,
  output logic                raster_done_o
);
  import gfx_pix_pkg::*;

  coord_t lo_x, hi_x, lo_y, hi_y;  // clipped bounds, hi is exclusive
  coord_t x0_q, x1_q, y1_q;
  logic   non_empty;
  logic   step, last_x, last_y;

  always_comb begin
    lo_x = (dest0_x_i > clip0_x_i) ? dest0_x_i : clip0_x_i;
    lo_y = (dest0_y_i > clip0_y_i) ? dest0_y_i : clip0_y_i;
    hi_x = (dest1_x_i < clip1_x_i) ? dest1_x_i : clip1_x_i;
    hi_y = (dest1_y_i < clip1_y_i) ? dest1_y_i : clip1_y_i;
    if (target_size_x_i < hi_x)
      hi_x = target_size_x_i;
    if (target_size_y_i < hi_y)
      hi_y = target_size_y_i;
  end

  assign non_empty = (lo_x < hi_x) && (lo_y < hi_y);
  assign step      = pix_valid_o & pix_ready_i;
  assign last_x    = (pix_x_o + 16'd1) == x1_q;  // x stays below x1, no wrap
  assign last_y    = (pix_y_o + 16'd1) == y1_q;

  always_ff @(posedge wb_clk_i) begin
    if (rst_i) begin
      pix_valid_o   <= 1'b0;
      raster_done_o <= 1'b1;  // idle counts as done
    end else if (rect_start_i) begin
      pix_valid_o   <= non_empty;
      raster_done_o <= ~non_empty;
    end else if (step && last_x && last_y) begin
      pix_valid_o   <= 1'b0;
      raster_done_o <= 1'b1;
    end
  end

  // geometry latched here, later register writes do not reach a running fill
  always_ff @(posedge wb_clk_i) begin
    if (rect_start_i) begin
      pix_x_o <= lo_x;
      pix_y_o <= lo_y;
      x0_q    <= lo_x;
      x1_q    <= hi_x;
      y1_q    <= hi_y;
    end else if (step) begin
      if (last_x) begin
        pix_x_o <= x0_q;  // wrap to next row
        pix_y_o <= pix_y_o + 16'd1;
      end else begin
        pix_x_o <= pix_x_o + 16'd1;
      end
    end
  end

endmodule

`default_nettype wire

/* gfx_pixel_render.sv */
//==========================================================================
// pixel renderer, one register stage from coordinate to memory word with
// byte select and lane replicated color
//==========================================================================
`default_nettype none

module gfx_pixel_render (
  input  logic                              wb_clk_i,
  input  logic                              rst_i,
  input  logic [gfx_pix_pkg::MEM_ADR_W-1:0] target_base_i,
  input  gfx_pix_pkg::coord_t               target_size_x_i,
  input  gfx_pix_pkg::depth_e               depth_i,
  input  gfx_pix_pkg::color_u               color_i,
  input  logic                              pix_valid_i,
  input  gfx_pix_pkg::coord_t               pix_x_i,
  input  gfx_pix_pkg::coord_t               pix_y_i,
  input  logic                              wr_ready_i,
  output logic                              pix_ready_o,
  output logic                              wr_valid_o,
  output logic [gfx_pix_pkg::MEM_ADR_W-1:0] wr_adr_o,
  output logic [3:0]                        wr_sel_o,
  output logic [31:0]                       wr_dat_o,
  output logic                              render_empty_o
);
  import gfx_pix_pkg::*;

  logic [31:0] pix_idx;
  logic [31:0] byte_off;
  logic [3:0]  sel;
  logic [31:0] dat;
  logic        take;

  always_comb begin
    pix_idx = pix_y_i * target_size_x_i + pix_x_i;
    case (depth_i)
      DEPTH_8: begin
        byte_off = pix_idx;
        sel      = 4'b0001 << byte_off[1:0];
        dat      = {4{color_i.b[0]}};
      end
      DEPTH_16: begin
        byte_off = pix_idx << 1;
        sel      = byte_off[1] ? 4'b1100 : 4'b0011;
        dat      = {2{color_i.h[0]}};
      end
      default: begin  // 32 bit, also code 3
        byte_off = pix_idx << 2;
        sel      = 4'b1111;
        dat      = color_i;
      end
    endcase
  end

  // accept when empty or when the held word leaves this cycle
  assign pix_ready_o    = ~wr_valid_o | wr_ready_i;
  assign take           = pix_valid_i & pix_ready_o;
  assign render_empty_o = ~wr_valid_o;

  always_ff @(posedge wb_clk_i) begin
    if (rst_i)
      wr_valid_o <= 1'b0;
    else if (pix_ready_o)
      wr_valid_o <= pix_valid_i;
  end

  always_ff @(posedge wb_clk_i) begin
    if (take) begin
      wr_adr_o <= target_base_i + byte_off[31:2];
      wr_sel_o <= sel;
      wr_dat_o <= dat;
    end
  end

endmodule

`default_nettype wire

/* gfx_mem_writer.sv */
//==========================================================================
// video memory write master, one entry, holds each classic cycle until ack
//==========================================================================
`default_nettype none

module gfx_mem_writer (
  input  logic                                 wb_clk_i,
  input  logic                                 rst_i,
  input  logic                                 wr_valid_i,
  input  logic [gfx_pix_pkg::MEM_ADR_W-1:0]    wr_adr_i,
  input  logic [gfx_reg_pkg::BUS_SEL_W-1:0]    wr_sel_i,
  input  logic [gfx_reg_pkg::BUS_DATA_W-1:0]   wr_dat_i,
  input  logic                                 wbm_ack_i,
  output logic                                 wr_ready_o,
  output logic                                 wbm_cyc_o,
  output logic                                 wbm_stb_o,
  output logic                                 wbm_we_o,
  output logic [31:0]                          wbm_adr_o,
  output logic [gfx_reg_pkg::BUS_SEL_W-1:0]    wbm_sel_o,
  output logic [gfx_reg_pkg::BUS_DATA_W-1:0]   wbm_dat_o,
  output logic                                 writer_idle_o
);
  import gfx_pix_pkg::*;

  logic                 cyc_q;
  logic [MEM_ADR_W-1:0] adr_q;

  assign wr_ready_o    = ~cyc_q;  // new word only when idle
  assign writer_idle_o = ~cyc_q;

  always_ff @(posedge wb_clk_i) begin
    if (rst_i)
      cyc_q <= 1'b0;
    else if (cyc_q)
      cyc_q <= ~wbm_ack_i;  // drop the cycle after ack
    else
      cyc_q <= wr_valid_i;
  end

  always_ff @(posedge wb_clk_i) begin
    if (wr_valid_i && !cyc_q) begin
      adr_q     <= wr_adr_i;
      wbm_sel_o <= wr_sel_i;
      wbm_dat_o <= wr_dat_i;
    end
  end

  // write only master, all three strobes move together
  assign wbm_cyc_o = cyc_q;
  assign wbm_stb_o = cyc_q;
  assign wbm_we_o  = cyc_q;
  assign wbm_adr_o = {adr_q, 2'b00};

endmodule

`default_nettype wire

/* gfx_top.sv */
//==========================================================================
// fill engine top level, register slave in, Wishbone write master out,
// with the busy flag that spans a whole fill
//==========================================================================
`default_nettype none

module gfx_top (
  input  logic                               wb_clk_i,
  input  logic                               rst_i,
  // CPU side slave
  input  logic                               wbs_cyc_i,
  input  logic                               wbs_stb_i,
  input  logic                               wbs_we_i,
  input  logic [gfx_reg_pkg::REG_ADR_W-1:0]  wbs_adr_i,
  input  logic [gfx_reg_pkg::BUS_DATA_W-1:0] wbs_dat_i,
  output logic [gfx_reg_pkg::BUS_DATA_W-1:0] wbs_dat_o,
  output logic                               wbs_ack_o,
  output logic                               wbs_err_o,
  // video memory write master
  output logic                               wbm_cyc_o,
  output logic                               wbm_stb_o,
  output logic                               wbm_we_o,
  output logic [31:0]                        wbm_adr_o,
  output logic [gfx_reg_pkg::BUS_SEL_W-1:0]  wbm_sel_o,
  output logic [gfx_reg_pkg::BUS_DATA_W-1:0] wbm_dat_o,
  input  logic                               wbm_ack_i
);
  import gfx_pix_pkg::*;

  logic                 busy_q;
  logic                 rect_start;
  logic [MEM_ADR_W-1:0] target_base;
  coord_t               size_x, size_y;
  coord_t               dest0_x, dest0_y, dest1_x, dest1_y;
  coord_t               clip0_x, clip0_y, clip1_x, clip1_y;
  color_u               color;
  depth_e               depth;

  logic                 pix_valid, pix_ready, raster_done;
  coord_t               pix_x, pix_y;
  logic                 wr_valid, wr_ready, render_empty, writer_idle;
  logic [MEM_ADR_W-1:0] wr_adr;
  logic [3:0]           wr_sel;
  logic [31:0]          wr_dat;

  // start wins over the drain check, the rasterizer is still idle then
  always_ff @(posedge wb_clk_i) begin
    if (rst_i)
      busy_q <= 1'b0;
    else if (rect_start)
      busy_q <= 1'b1;
    else if (raster_done && render_empty && writer_idle)
      busy_q <= 1'b0;
  end

  gfx_reg_slave u_reg_slave (
    .wb_clk_i        (wb_clk_i),
    .rst_i           (rst_i),
    .wbs_cyc_i       (wbs_cyc_i),
    .wbs_stb_i       (wbs_stb_i),
    .wbs_we_i        (wbs_we_i),
    .wbs_adr_i       (wbs_adr_i),
    .wbs_dat_i       (wbs_dat_i),
    .busy_i          (busy_q),
    .wbs_dat_o       (wbs_dat_o),
    .wbs_ack_o       (wbs_ack_o),
    .wbs_err_o       (wbs_err_o),
    .rect_start_o    (rect_start),
    .target_base_o   (target_base),
    .target_size_x_o (size_x),
    .target_size_y_o (size_y),
    .dest0_x_o       (dest0_x),
    .dest0_y_o       (dest0_y),
    .dest1_x_o       (dest1_x),
    .dest1_y_o       (dest1_y),
    .clip0_x_o       (clip0_x),
    .clip0_y_o       (clip0_y),
    .clip1_x_o       (clip1_x),
    .clip1_y_o       (clip1_y),
    .color_o         (color),
    .depth_o         (depth)
  );

  gfx_rect_raster u_rect_raster (
    .wb_clk_i        (wb_clk_i),
    .rst_i           (rst_i),
    .rect_start_i    (rect_start),
    .target_size_x_i (size_x),
    .target_size_y_i (size_y),
    .dest0_x_i       (dest0_x),
    .dest0_y_i       (dest0_y),
    .dest1_x_i       (dest1_x),
    .dest1_y_i       (dest1_y),
    .clip0_x_i       (clip0_x),
    .clip0_y_i       (clip0_y),
    .clip1_x_i       (clip1_x),
    .clip1_y_i       (clip1_y),
    .pix_ready_i     (pix_ready),
    .pix_valid_o     (pix_valid),
    .pix_x_o         (pix_x),
    .pix_y_o         (pix_y),
    .raster_done_o   (raster_done)
  );

  gfx_pixel_render u_pixel_render (
    .wb_clk_i        (wb_clk_i),
    .rst_i           (rst_i),
    .target_base_i   (target_base),
    .target_size_x_i (size_x),
    .depth_i         (depth),
    .color_i         (color),
    .pix_valid_i     (pix_valid),
    .pix_x_i         (pix_x),
    .pix_y_i         (pix_y),
    .wr_ready_i      (wr_ready),
    .pix_ready_o     (pix_ready),
    .wr_valid_o      (wr_valid),
    .wr_adr_o        (wr_adr),
    .wr_sel_o        (wr_sel),
    .wr_dat_o        (wr_dat),
    .render_empty_o  (render_empty)
  );

  gfx_mem_writer u_mem_writer (
    .wb_clk_i      (wb_clk_i),
    .rst_i         (rst_i),
    .wr_valid_i    (wr_valid),
    .wr_adr_i      (wr_adr),
    .wr_sel_i      (wr_sel),
    .wr_dat_i      (wr_dat),
    .wbm_ack_i     (wbm_ack_i),
    .wr_ready_o    (wr_ready),
    .wbm_cyc_o     (wbm_cyc_o),
    .wbm_stb_o     (wbm_stb_o),
    .wbm_we_o      (wbm_we_o),
    .wbm_adr_o     (wbm_adr_o),
    .wbm_sel_o     (wbm_sel_o),
    .wbm_dat_o     (wbm_dat_o),
    .writer_idle_o (writer_idle)
  );

endmodule

`default_nettype wire

/* tb_gfx_mem.sv */
//==========================================================================
// video memory model for the testbench, byte lanes with 0 to 3 wait cycles
//==========================================================================
`default_nettype none

module tb_gfx_mem #(
  parameter int WORDS = 1024
) (
  input  logic        wb_clk_i,
  input  logic        rst_i,
  input  logic        cyc_i,
  input  logic        stb_i,
  input  logic        we_i,
  input  logic [31:0] adr_i,
  input  logic [3:0]  sel_i,
  input  logic [31:0] dat_i,
  output logic        ack_o
);
  timeunit 1ns;
  timeprecision 1ps;

  logic [7:0]  mem_q [0:WORDS-1][0:3];
  logic [31:0] rng_q;
  logic [1:0]  left_q;
  logic        armed_q;  // wait drawn for the current cycle

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] v;
    v = s ^ (s << 13);
    v = v ^ (v >> 17);
    return v ^ (v << 5);
  endfunction

  // start contents, every address bit shows up in the byte
  function automatic logic [7:0] pattern_byte(input int a);
    return 8'(a ^ (a >> 5) ^ 'h3c);
  endfunction

  initial begin
    for (int w = 0; w < WORDS; w++)
      for (int l = 0; l < 4; l++)
        mem_q[w][l] = pattern_byte(w * 4 + l);
  end

  always @(posedge wb_clk_i) begin
    logic [31:0] r;
    logic [1:0]  left;
    if (rst_i) begin
      ack_o   <= 1'b0;
      armed_q <= 1'b0;
      left_q  <= '0;
      rng_q   <= 32'd73;
    end else begin
      ack_o <= 1'b0;
      if (cyc_i && stb_i && !ack_o) begin
        r    = xorshift32(rng_q);
        left = armed_q ? left_q : r[1:0];
        if (!armed_q)
          rng_q <= r;
        if (left == 2'd0) begin
          ack_o   <= 1'b1;
          armed_q <= 1'b0;
          for (int l = 0; l < 4; l++)
            if (we_i && sel_i[l])
              mem_q[(adr_i >> 2) % WORDS][l] <= dat_i[8*l +: 8];
        end else begin
          left_q  <= left - 2'd1;  // count down the wait
          armed_q <= 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* tb_gfx_top.sv */
//==========================================================================
// testbench for the fill engine, random fills checked write by write
// against a model of the clipped rectangle and the video memory
//==========================================================================
`default_nettype none

module tb_gfx_top;
  timeunit 1ns;
  timeprecision 1ps;
  import gfx_reg_pkg::*;
  import gfx_pix_pkg::*;

  localparam int N_TESTS   = 20;  // fills in the whole run
  localparam int MAX_AREA  = 32 * 16;
  localparam int MEM_WORDS = 1024;

  logic                  clk, rst;
  logic                  wbs_cyc, wbs_stb, wbs_we, wbs_ack, wbs_err;
  logic [REG_ADR_W-1:0]  wbs_adr;
  logic [BUS_DATA_W-1:0] wbs_dat, wbs_rdat;
  logic                  wbm_cyc, wbm_stb, wbm_we, wbm_ack;
  logic [31:0]           wbm_adr;
  logic [BUS_SEL_W-1:0]  wbm_sel;
  logic [BUS_DATA_W-1:0] wbm_dat;

  logic [31:0] rng_q;
  int          mismatch_cnt, other_cnt, n_writes;
  logic [31:0] exp_adr_q [$];
  logic [3:0]  exp_sel_q [$];
  logic [31:0] exp_dat_q [$];
  logic [7:0]  exp_mem [0:MEM_WORDS-1][0:3];
  // setup of the next fill
  int          t_base, t_sx, t_sy, t_depth, d0x, d0y, d1x, d1y, c0x, c0y, c1x, c1y;
  logic [31:0] t_color;

  gfx_top u_gfx_top (
    .wb_clk_i  (clk),
    .rst_i     (rst),
    .wbs_cyc_i (wbs_cyc),
    .wbs_stb_i (wbs_stb),
    .wbs_we_i  (wbs_we),
    .wbs_adr_i (wbs_adr),
    .wbs_dat_i (wbs_dat),
    .wbs_dat_o (wbs_rdat),
    .wbs_ack_o (wbs_ack),
    .wbs_err_o (wbs_err),
    .wbm_cyc_o (wbm_cyc),
    .wbm_stb_o (wbm_stb),
    .wbm_we_o  (wbm_we),
    .wbm_adr_o (wbm_adr),
    .wbm_sel_o (wbm_sel),
    .wbm_dat_o (wbm_dat),
    .wbm_ack_i (wbm_ack)
  );

  tb_gfx_mem #(.WORDS(MEM_WORDS)) u_mem (
    .wb_clk_i (clk),
    .rst_i    (rst),
    .cyc_i    (wbm_cyc),
    .stb_i    (wbm_stb),
    .we_i     (wbm_we),
    .adr_i    (wbm_adr),
    .sel_i    (wbm_sel),
    .dat_i    (wbm_dat),
    .ack_o    (wbm_ack)
  );

  always #10 clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] v;
    v = s ^ (s << 13);
    v = v ^ (v >> 17);
    return v ^ (v << 5);
  endfunction

  function automatic int rand_range(input int lo, input int hi);
    rng_q = xorshift32(rng_q);
    return lo + int'(rng_q % (hi - lo + 1));
  endfunction

  function automatic int min_of(input int a, input int b);
    return (a < b) ? a : b;
  endfunction

  task automatic check_reg(input string name, input logic [BUS_DATA_W-1:0] got,
                           input logic [BUS_DATA_W-1:0] exp);
    if (got !== exp) begin
      $display("Mismatch %s: got %h expected %h", name, got, exp);
      mismatch_cnt++;
    end
  endtask

  task automatic check_adr(input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("Mismatch wbm_adr_o: got %h expected %h", got, exp);
      mismatch_cnt++;
    end
  endtask

  task automatic check_sel(input logic [BUS_SEL_W-1:0] got, input logic [BUS_SEL_W-1:0] exp);
    if (got !== exp) begin
      $display("Mismatch wbm_sel_o: got %h expected %h", got, exp);
      mismatch_cnt++;
    end
  endtask

  task automatic check_dat(input logic [BUS_DATA_W-1:0] got, input logic [BUS_DATA_W-1:0] exp);
    if (got !== exp) begin
      $display("Mismatch wbm_dat_o: got %h expected %h", got, exp);
      mismatch_cnt++;
    end
  endtask

  task automatic check_word(input int w, input logic [BUS_DATA_W-1:0] got,
                            input logic [BUS_DATA_W-1:0] exp);
    if (got !== exp) begin
      $display("Mismatch mem_q[%0d]: got %h expected %h", w, got, exp);
      mismatch_cnt++;
    end
  endtask

  // one classic cycle, response sampled on the edge after it was registered
  task automatic bus_access(input logic we, input int idx, input logic [31:0] wdat,
                            output logic [31:0] rdat, output logic err);
    int n;
    @(posedge clk);
    wbs_cyc <= 1'b1;
    wbs_stb <= 1'b1;
    wbs_we  <= we;
    wbs_adr <= idx[REG_ADR_W-1:0];
    wbs_dat <= wdat;
    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while (!wbs_ack && !wbs_err && n < 16);
    rdat = wbs_rdat;
    err  = wbs_err;
    if (!wbs_ack && !wbs_err) begin
      $display("register slave gave no response at index %0d", idx);
      other_cnt++;
    end
    wbs_cyc <= 1'b0;
    wbs_stb <= 1'b0;
    wbs_we  <= 1'b0;
  endtask

  task automatic reg_write(input int idx, input logic [31:0] wdat);
    logic [31:0] rd;
    logic        err;
    bus_access(1'b1, idx, wdat, rd, err);
    if (err) begin
      $display("write to register %0d got an error response", idx);
      other_cnt++;
    end
  endtask

  task automatic reg_read(input int idx, output logic [31:0] rd);
    logic err;
    bus_access(1'b0, idx, '0, rd, err);
    if (err) begin
      $display("read of register %0d got an error response", idx);
      other_cnt++;
    end
  endtask

  // expected writes of the clipped rectangle, in row-major order
  task automatic model_fill();
    int x_lo, x_hi, y_lo, y_hi, bpp, off, word;
    logic [3:0]  sel;
    logic [31:0] dat;
    x_lo = (d0x > c0x) ? d0x : c0x;
    y_lo = (d0y > c0y) ? d0y : c0y;
    x_hi = min_of(min_of(d1x, c1x), t_sx);
    y_hi = min_of(min_of(d1y, c1y), t_sy);
    bpp  = (t_depth == 0) ? 1 : (t_depth == 1) ? 2 : 4;
    for (int y = y_lo; y < y_hi; y++) begin
      for (int x = x_lo; x < x_hi; x++) begin
        off  = (y * t_sx + x) * bpp;
        word = t_base / 4 + off / 4;
        sel  = 4'((1 << bpp) - 1) << (off % 4);
        for (int l = 0; l < 4; l++) begin
          dat[8*l +: 8] = t_color[8*(l % bpp) +: 8];
          if (sel[l])
            exp_mem[word % MEM_WORDS][l] = dat[8*l +: 8];
        end
        exp_adr_q.push_back(32'(word * 4));
        exp_sel_q.push_back(sel);
        exp_dat_q.push_back(dat);
      end
    end
  endtask

  task automatic wait_idle();
    logic [31:0] st;
    do begin
      reg_read(REG_STATUS, st);
    end while (st[STAT_BUSY_BIT]);
  endtask

  task automatic launch_fill(input logic twice);
    reg_write(REG_TARGET_BASE, t_base);
    reg_write(REG_TARGET_SIZE, {16'(t_sy), 16'(t_sx)});
    reg_write(REG_DEST0, {16'(d0y), 16'(d0x)});
    reg_write(REG_DEST1, {16'(d1y), 16'(d1x)});
    reg_write(REG_CLIP0, {16'(c0y), 16'(c0x)});
    reg_write(REG_CLIP1, {16'(c1y), 16'(c1x)});
    reg_write(REG_COLOR, t_color);
    reg_write(REG_DEPTH, t_depth);
    model_fill();
    reg_write(REG_CONTROL, 32'h1 << CTRL_RECT_BIT);
    if (twice)
      reg_write(REG_CONTROL, 32'h1 << CTRL_RECT_BIT);  // must be ignored
    wait_idle();
    if (exp_adr_q.size() != 0) begin
      $display("fill ended with %0d expected writes never seen", exp_adr_q.size());
      other_cnt++;
      exp_adr_q.delete();
      exp_sel_q.delete();
      exp_dat_q.delete();
    end
  endtask

  // 32x16 target, clip covering it, random base and color
  task automatic pick_target();
    t_base  = rand_range(0, 1023);
    t_sx    = 32;
    t_sy    = 16;
    c0x     = 0;
    c0y     = 0;
    c1x     = 32;
    c1y     = 16;
    t_color = xorshift32(rng_q);
    rng_q   = t_color;
  endtask

  task automatic pick_inner_rect(input int w, input int h);
    d0x = rand_range(0, 31 - w);
    d0y = rand_range(0, 15 - h);
    d1x = d0x + rand_range(1, w);
    d1y = d0y + rand_range(1, h);
  endtask

  // every acked write must be the model's next pixel
  always @(posedge clk) begin
    if (!rst && wbm_cyc && wbm_stb && wbm_we && wbm_ack) begin
      n_writes++;
      if (exp_adr_q.size() == 0) begin
        $display("write to %h that the model does not expect", wbm_adr);
        other_cnt++;
      end else begin
        check_adr(wbm_adr, exp_adr_q.pop_front());
        check_sel(wbm_sel, exp_sel_q.pop_front());
        check_dat(wbm_dat, exp_dat_q.pop_front());
      end
    end
  end

  initial begin
    #(N_TESTS * MAX_AREA * 10 * 20);
    $display("timeout, the fill engine did not finish the tests in time");
    $display("sim failed");
    $finish;
  end

  initial begin
    logic [31:0] rd;
    logic [31:0] vals [REG_TARGET_BASE:REG_DEPTH];
    logic        err;
    clk          = 1'b0;
    rst          = 1'b1;
    wbs_cyc      = 1'b0;
    wbs_stb      = 1'b0;
    wbs_we       = 1'b0;
    wbs_adr      = '0;
    wbs_dat      = '0;
    rng_q        = 32'd73;
    mismatch_cnt = 0;
    other_cnt    = 0;
    n_writes     = 0;
    for (int w = 0; w < MEM_WORDS; w++)
      for (int l = 0; l < 4; l++)
        exp_mem[w][l] = 8'((w * 4 + l) ^ ((w * 4 + l) >> 5) ^ 'h3c);
    repeat (10) @(posedge clk);
    rst <= 1'b0;

    // register readback, status idle
    for (int i = REG_TARGET_BASE; i <= REG_DEPTH; i++) begin
      vals[i] = xorshift32(rng_q);
      rng_q   = vals[i];
      reg_write(i, vals[i]);
    end
    for (int i = REG_TARGET_BASE; i <= REG_DEPTH; i++) begin
      reg_read(i, rd);
      check_reg("wbs_dat_o", rd, vals[i]);
    end
    reg_read(REG_STATUS, rd);
    check_reg("status", rd, 32'h0);

    // 32 bit fills inside the target
    for (int n = 0; n < 3; n++) begin
      pick_target();
      t_depth = 2;
      pick_inner_rect(4, 3);
      launch_fill(1'b0);
    end

    // clip rectangle and target edge, last one empty
    for (int n = 0; n < 8; n++) begin
      pick_target();
      t_depth = rand_range(0, 2);
      c0x     = rand_range(0, 12);
      c1x     = rand_range(12, 40);
      c0y     = rand_range(0, 6);
      c1y     = rand_range(6, 20);
      d0x     = rand_range(0, 36);
      d0y     = rand_range(0, 18);
      d1x     = (n == 7) ? d0x : d0x + rand_range(0, 10);
      d1y     = d0y + rand_range(0, 5);
      launch_fill(1'b0);
    end

    // 8 and 16 bit lanes, code 3 as 32 bit, then the memory contents
    for (int n = 0; n < 6; n++) begin
      pick_target();
      t_depth = n % 4;
      pick_inner_rect(8, 4);
      launch_fill(1'b0);
    end
    for (int w = 0; w < MEM_WORDS; w++)
      check_word(w, {u_mem.mem_q[w][3], u_mem.mem_q[w][2], u_mem.mem_q[w][1],
                     u_mem.mem_q[w][0]},
                 {exp_mem[w][3], exp_mem[w][2], exp_mem[w][1], exp_mem[w][0]});

    // whole target under random ack delays
    for (int n = 0; n < 2; n++) begin
      pick_target();
      t_depth = 2 - n * 2;
      d0x     = 0;
      d0y     = 0;
      d1x     = 32;
      d1y     = 16;
      launch_fill(1'b0);
    end

    // unmapped index, status write, start while busy
    bus_access(1'b0, rand_range(REG_DEPTH + 1, 15), '0, rd, err);
    if (!err) begin
      $display("unmapped register index answered without an error");
      other_cnt++;
    end
    bus_access(1'b1, REG_STATUS, 32'h1, rd, err);
    if (!err) begin
      $display("write to the status register answered without an error");
      other_cnt++;
    end
    pick_target();
    t_depth = 1;
    pick_inner_rect(6, 3);
    launch_fill(1'b1);

    $display("done: %0d mismatches, %0d other errors, %0d writes", mismatch_cnt,
             other_cnt, n_writes);
    if (mismatch_cnt == 0 && other_cnt == 0)
      $display("sim passed");
    else
      $display("sim failed");
    $finish;
  end

endmodule

`default_nettype wire

/* gfx_top.f */
gfx_reg_pkg.sv
gfx_pix_pkg.sv
gfx_reg_slave.sv
gfx_rect_raster.sv
gfx_pixel_render.sv
gfx_mem_writer.sv
gfx_top.sv
tb_gfx_mem.sv
tb_gfx_top.sv
